// ==== rtl/face_pkg.sv ====
`default_nettype none

package face_pkg;

  localparam int FRAME_WIDTH  = 16;
  localparam int FRAME_HEIGHT = 8;
  localparam int NUM_SCALES   = 2;
  localparam int NUM_STAGES   = 4;
  localparam int RESULT_DEPTH = 16;

  typedef logic [7:0]         pixel_t;
  typedef logic [3:0]         coord_x_t;
  typedef logic [2:0]         coord_y_t;
  typedef logic [1:0]         tile_idx_t;
  typedef logic [11:0]        quad_sum_t;
  typedef logic signed [13:0] feat_diff_t;

  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
  } pixel_pos_t;

  typedef struct packed {
    quad_sum_t tl;
    quad_sum_t tr;
    quad_sum_t bl;
    quad_sum_t br;
  } quad_sums_t;

  // horizontal = 0 compares left against right, 1 compares top against bottom
  typedef struct packed {
    logic              horizontal;
    logic signed [7:0] threshold;
  } stage_t;

  typedef struct packed {
    logic      scale;
    tile_idx_t tile_x;
    tile_idx_t tile_y;
  } result_t;

  // Per-pixel thresholds that scale with the half-tile pixel count
  localparam stage_t STAGE_TABLE [NUM_STAGES] = '{
    '{1'b0, 8'sd12},
    '{1'b1, -8'sd6},
    '{1'b0, -8'sd60},
    '{1'b1, -8'sd20}
  };

  // Stages whose difference is reversed before the compare
  localparam logic [NUM_STAGES-1:0] STAGE_NEGATE = 4'b0100;

  typedef enum logic [1:0] {
    EVAL_IDLE,
    EVAL_LOAD,
    EVAL_STAGE,
    EVAL_OFFER
  } eval_state_t;

endpackage

`default_nettype wire

// ==== rtl/tile_accumulator.sv ====
`default_nettype none

module tile_accumulator
  import face_pkg::*;
#(
  parameter int TILE_SHIFT = 2
)
(
  input  wire              clk,
  input  wire              reset,
  input  wire pixel_t      i_pixel,
  input  wire pixel_pos_t  i_pos,
  input  wire              i_take,
  input  wire tile_idx_t   i_tile_sel,
  output quad_sums_t       o_quads,
  output logic             o_band_done,
  output tile_idx_t        o_band
);

  localparam int NUM_COLS = FRAME_WIDTH >> TILE_SHIFT;
  localparam int COL_BITS = (NUM_COLS > 1) ? $clog2(NUM_COLS) : 1;

  // One set of quadrant totals per tile column of the current band
  quad_sums_t sums [NUM_COLS];

  logic [TILE_SHIFT-1:0] low_x;
  logic [TILE_SHIFT-1:0] low_y;
  logic [COL_BITS-1:0]   col;
  logic                  first_in_tile;
  logic                  band_end;
  quad_sums_t            base;
  quad_sums_t            next_quads;

  assign low_x         = i_pos.x[TILE_SHIFT-1:0];
  assign low_y         = i_pos.y[TILE_SHIFT-1:0];
  assign col           = COL_BITS'(i_pos.x >> TILE_SHIFT);
  assign first_in_tile = (low_x == '0) && (low_y == '0);
  assign band_end      = (i_pos.x == coord_x_t'(FRAME_WIDTH - 1)) && (&low_y);

  assign o_quads = sums[i_tile_sel[COL_BITS-1:0]];

  always_comb
  begin
    // First pixel of a tile starts from zero totals
    base       = first_in_tile ? '0 : sums[col];
    next_quads = base;
    // Upper bit of the in-tile offset picks the quadrant
    case ({low_y[TILE_SHIFT-1], low_x[TILE_SHIFT-1]})
      2'b00:   next_quads.tl = base.tl + quad_sum_t'(i_pixel);
      2'b01:   next_quads.tr = base.tr + quad_sum_t'(i_pixel);
      2'b10:   next_quads.bl = base.bl + quad_sum_t'(i_pixel);
      default: next_quads.br = base.br + quad_sum_t'(i_pixel);
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (i_take)
    begin
      sums[col] <= next_quads;
    end
    if (i_take && band_end)
    begin
      o_band <= tile_idx_t'(i_pos.y >> TILE_SHIFT);
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      o_band_done <= 1'b0;
    end
    else
    begin
      o_band_done <= i_take && band_end;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cascade_evaluator.sv ====
`default_nettype none

module cascade_evaluator
  import face_pkg::*;
#(
  parameter int SCALE      = 0,
  parameter int TILE_SHIFT = 2
)
(
  input  wire              clk,
  input  wire              reset,
  input  wire              i_band_done,
  input  wire tile_idx_t   i_band,
  input  wire quad_sums_t  i_quads,
  input  wire              i_cand_taken,
  output tile_idx_t        o_tile_sel,
  output logic             o_busy,
  output logic             o_cand_valid,
  output result_t          o_cand
);

  localparam int NUM_COLS   = FRAME_WIDTH >> TILE_SHIFT;
  // log2 of the pixel count in one half tile
  localparam int HALF_SHIFT = 2 * TILE_SHIFT - 1;

  eval_state_t                     state;
  tile_idx_t                       tile;
  tile_idx_t                       band;
  logic [$clog2(NUM_STAGES)-1:0]   stage_idx;
  quad_sums_t                      quads_q;
  stage_t                          cur_stage;
  feat_diff_t                      sum_a;
  feat_diff_t                      sum_b;
  feat_diff_t                      diff;
  feat_diff_t                      limit;
  logic                            stage_pass;
  logic                            last_tile;

  assign last_tile    = tile == tile_idx_t'(NUM_COLS - 1);
  assign o_tile_sel   = tile;
  assign o_busy       = i_band_done || (state != EVAL_IDLE);
  assign o_cand_valid = state == EVAL_OFFER;
  assign o_cand       = '{scale: 1'(SCALE), tile_x: tile, tile_y: band};

  always_comb
  begin
    cur_stage = STAGE_TABLE[stage_idx];
    if (cur_stage.horizontal)
    begin
      sum_a = feat_diff_t'(quads_q.tl) + feat_diff_t'(quads_q.tr);
      sum_b = feat_diff_t'(quads_q.bl) + feat_diff_t'(quads_q.br);
    end
    else
    begin
      sum_a = feat_diff_t'(quads_q.tl) + feat_diff_t'(quads_q.bl);
      sum_b = feat_diff_t'(quads_q.tr) + feat_diff_t'(quads_q.br);
    end
    diff       = STAGE_NEGATE[stage_idx] ? (sum_b - sum_a) : (sum_a - sum_b);
    limit      = feat_diff_t'($signed(cur_stage.threshold)) <<< HALF_SHIFT;
    stage_pass = diff >= limit;
  end

  // Sums stay put in the accumulator while we are busy
  always_ff @(posedge clk)
  begin
    if (state == EVAL_IDLE && i_band_done)
    begin
      band <= i_band;
    end
    if (state == EVAL_LOAD)
    begin
      quads_q <= i_quads;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= EVAL_IDLE;
      tile      <= '0;
      stage_idx <= '0;
    end
    else
    begin
      case (state)
        EVAL_IDLE:
          if (i_band_done)
          begin
            tile  <= '0;
            state <= EVAL_LOAD;
          end
        EVAL_LOAD:
        begin
          stage_idx <= '0;
          state     <= EVAL_STAGE;
        end
        EVAL_STAGE:
          if (!stage_pass)
          begin
            // Early exit to the next tile
            tile  <= tile + 1'b1;
            state <= last_tile ? EVAL_IDLE : EVAL_LOAD;
          end
          else if (stage_idx == NUM_STAGES - 1)
          begin
            state <= EVAL_OFFER;
          end
          else
          begin
            stage_idx <= stage_idx + 1'b1;
          end
        default:
          if (i_cand_taken)
          begin
            tile  <= tile + 1'b1;
            state <= last_tile ? EVAL_IDLE : EVAL_LOAD;
          end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/result_fifo.sv ====
`default_nettype none

module result_fifo
  import face_pkg::*;
(
  input  wire           clk,
  input  wire           reset,
  input  wire           i_write,
  input  wire result_t  i_data,
  input  wire           i_read,
  output result_t       o_data,
  output logic          o_valid,
  output logic          o_empty,
  output logic          o_full
);

  localparam int PTR_BITS = $clog2(RESULT_DEPTH);

  result_t             mem [RESULT_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS:0]   count;
  logic                do_write;
  logic                do_read;

  assign o_empty  = count == '0;
  assign o_full   = count == (PTR_BITS + 1)'(RESULT_DEPTH);
  assign do_write = i_write && !o_full;
  assign do_read  = i_read && !o_empty;

  always_ff @(posedge clk)
  begin
    if (do_write)
    begin
      mem[wr_ptr] <= i_data;
    end
    if (do_read)
    begin
      o_data <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      o_valid <= 1'b0;
    end
    else
    begin
      // Pointers wrap naturally at the power-of-two depth
      wr_ptr  <= wr_ptr + PTR_BITS'(do_write);
      rd_ptr  <= rd_ptr + PTR_BITS'(do_read);
      count   <= count + (PTR_BITS + 1)'(do_write) - (PTR_BITS + 1)'(do_read);
      o_valid <= do_read;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/face_detection.sv ====
`default_nettype none

module face_detection
  import face_pkg::*;
(
  input  wire          clk,
  input  wire          reset,
  input  wire pixel_t  i_pixel,
  input  wire          i_pixel_strobe,
  input  wire          i_read_result,
  output logic         o_ready,
  output logic         o_frame_end,
  output result_t      o_result_data,
  output logic         o_result_valid,
  output logic         o_result_empty
);

  pixel_pos_t              pos;
  logic                    pixel_take;
  logic                    last_pixel;
  logic                    frame_pending;
  logic [NUM_SCALES-1:0]   band_done;
  logic [NUM_SCALES-1:0]   busy;
  logic [NUM_SCALES-1:0]   cand_valid;
  logic [NUM_SCALES-1:0]   grant;
  tile_idx_t               band     [NUM_SCALES];
  tile_idx_t               tile_sel [NUM_SCALES];
  quad_sums_t              quads    [NUM_SCALES];
  result_t                 cand     [NUM_SCALES];
  result_t                 write_data;
  logic                    fifo_full;

  // Strobes only count while no detector is evaluating
  assign o_ready     = ~|busy;
  assign pixel_take  = i_pixel_strobe && o_ready;
  assign last_pixel  = (pos.x == coord_x_t'(FRAME_WIDTH - 1)) &&
                       (pos.y == coord_y_t'(FRAME_HEIGHT - 1));
  assign o_frame_end = frame_pending && o_ready;

  // Coordinate iterator, x first then y
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pos           <= '0;
      frame_pending <= 1'b0;
    end
    else if (pixel_take)
    begin
      frame_pending <= last_pixel;
      if (pos.x == coord_x_t'(FRAME_WIDTH - 1))
      begin
        pos.x <= '0;
        pos.y <= last_pixel ? '0 : pos.y + 1'b1;
      end
      else
      begin
        pos.x <= pos.x + 1'b1;
      end
    end
  end

  // Scale 0 first, so results come out in band then scale order
  assign grant[0]   = cand_valid[0] && !fifo_full;
  assign grant[1]   = cand_valid[1] && !busy[0] && !cand_valid[0] && !fifo_full;
  assign write_data = grant[0] ? cand[0] : cand[1];

  for (genvar g = 0; g < NUM_SCALES; g++)
  begin : g_scale
    tile_accumulator #(
      .TILE_SHIFT (2 + g)
    ) u_accum (
      .clk         (clk),
      .reset       (reset),
      .i_pixel     (i_pixel),
      .i_pos       (pos),
      .i_take      (pixel_take),
      .i_tile_sel  (tile_sel[g]),
      .o_quads     (quads[g]),
      .o_band_done (band_done[g]),
      .o_band      (band[g])
    );

    cascade_evaluator #(
      .SCALE      (g),
      .TILE_SHIFT (2 + g)
    ) u_eval (
      .clk          (clk),
      .reset        (reset),
      .i_band_done  (band_done[g]),
      .i_band       (band[g]),
      .i_quads      (quads[g]),
      .i_cand_taken (grant[g]),
      .o_tile_sel   (tile_sel[g]),
      .o_busy       (busy[g]),
      .o_cand_valid (cand_valid[g]),
      .o_cand       (cand[g])
    );
  end

  result_fifo u_result (
    .clk     (clk),
    .reset   (reset),
    .i_write (|grant),
    .i_data  (write_data),
    .i_read  (i_read_result),
    .o_data  (o_result_data),
    .o_valid (o_result_valid),
    .o_empty (o_result_empty),
    .o_full  (fifo_full)
  );

endmodule

`default_nettype wire

// ==== sim/tb_face_model.svh ====
`ifndef TB_FACE_MODEL_SVH
`define TB_FACE_MODEL_SVH

// Pattern 0 is flat grey, 1 the column gradient, 2 the gradient with noise
task automatic fill_frame(input int pattern);
  for (int y = 0; y < FRAME_HEIGHT; y++)
  begin
    for (int x = 0; x < FRAME_WIDTH; x++)
    begin
      if (pattern == 0)
      begin
        frame[y][x] = 8'd100;
      end
      else if (pattern == 1)
      begin
        frame[y][x] = GRAD_VALS[(x % 8) / 2];
      end
      else
      begin
        frame[y][x] = pixel_t'(int'(GRAD_VALS[(x % 8) / 2]) - 40 + $urandom_range(0, 80));
      end
    end
  end
endtask

// Waits on o_ready before each pixel and strobes garbage while busy when inject is set
task automatic send_frame(input bit inject);
  for (int y = 0; y < FRAME_HEIGHT; y++)
  begin
    for (int x = 0; x < FRAME_WIDTH; x++)
    begin
      while (!o_ready)
      begin
        i_pixel_strobe = inject;
        i_pixel        = pixel_t'($urandom);
        @(posedge clk);
        #2;
      end
      i_pixel        = frame[y][x];
      i_pixel_strobe = 1'b1;
      @(posedge clk);
      #2;
      i_pixel_strobe = 1'b0;
    end
  end
  frames_sent++;
  // Evaluation of the last bands
  while (!o_ready)
  begin
    i_pixel_strobe = inject;
    i_pixel        = pixel_t'($urandom);
    @(posedge clk);
    #2;
  end
  i_pixel_strobe = 1'b0;
  assert (o_frame_end)
  else
  begin
    $display("Mismatch at %0t: o_frame_end low after the last pixel", $time);
    error_count++;
  end
endtask

// Reads until a read strobe brings no data in the next cycle
task automatic drain_results();
  bit got_data;
  got_q.delete();
  got_data = 1'b1;
  while (got_data && got_q.size() <= RESULT_DEPTH)
  begin
    i_read_result = 1'b1;
    @(posedge clk);
    #2;
    i_read_result = 1'b0;
    got_data      = o_result_valid;
    if (got_data)
    begin
      got_q.push_back(o_result_data);
    end
  end
endtask

// Stage rule per tile, in order scale, band, tile column
function automatic void build_expected();
  int      tsize;
  int      half_px;
  int      left_sum;
  int      right_sum;
  int      top_sum;
  int      bot_sum;
  int      diff;
  bit      pass;
  result_t r;
  exp_q.delete();
  for (int s = 0; s < NUM_SCALES; s++)
  begin
    tsize   = 4 << s;
    half_px = tsize * tsize / 2;
    for (int by = 0; by < FRAME_HEIGHT / tsize; by++)
    begin
      for (int bx = 0; bx < FRAME_WIDTH / tsize; bx++)
      begin
        left_sum  = 0;
        right_sum = 0;
        top_sum   = 0;
        bot_sum   = 0;
        for (int dy = 0; dy < tsize; dy++)
        begin
          for (int dx = 0; dx < tsize; dx++)
          begin
            if (dx < tsize / 2)
              left_sum += frame[by * tsize + dy][bx * tsize + dx];
            else
              right_sum += frame[by * tsize + dy][bx * tsize + dx];
            if (dy < tsize / 2)
              top_sum += frame[by * tsize + dy][bx * tsize + dx];
            else
              bot_sum += frame[by * tsize + dy][bx * tsize + dx];
          end
        end
        pass = 1'b1;
        for (int k = 0; k < NUM_STAGES && pass; k++)
        begin
          diff = STAGE_TABLE[k].horizontal ? (top_sum - bot_sum) : (left_sum - right_sum);
          // Stage 2 is an upper bound
          if (k == 2)
            diff = -diff;
          pass = diff >= int'(STAGE_TABLE[k].threshold) * half_px;
        end
        if (pass)
        begin
          r.scale  = s[0];
          r.tile_x = bx[1:0];
          r.tile_y = by[1:0];
          exp_q.push_back(r);
        end
      end
    end
  end
endfunction

task automatic compare_results();
  assert (got_q.size() == exp_q.size())
  else
  begin
    $display("Mismatch at %0t: %0d results read, %0d expected",
             $time, got_q.size(), exp_q.size());
    error_count++;
  end
  for (int i = 0; i < got_q.size() && i < exp_q.size(); i++)
  begin
    assert (got_q[i] == exp_q[i])
    else
    begin
      $display("Mismatch at %0t: entry %0d is %h, expected %h", $time, i, got_q[i], exp_q[i]);
      error_count++;
    end
  end
  assert (o_result_empty && frame_ends == frames_sent)
  else
  begin
    $display("Mismatch at %0t: empty %b, %0d frame ends for %0d frames",
             $time, o_result_empty, frame_ends, frames_sent);
    error_count++;
  end
endtask

`endif

// ==== sim/tb_face_detection.sv ====
`default_nettype none

module tb_face_detection
  import face_pkg::*;
();

  localparam int CYCLE_LIMIT = 8 * (FRAME_WIDTH * FRAME_HEIGHT + 200);
  localparam int ALL_TILES   = (FRAME_WIDTH / 4) * (FRAME_HEIGHT / 4) +
                               (FRAME_WIDTH / 8) * (FRAME_HEIGHT / 8);
  // Column levels by x mod 8 with the bright side on the left of every tile at both scales
  localparam pixel_t GRAD_VALS [4] = '{8'd150, 8'd110, 8'd100, 8'd60};

  logic    clk;
  logic    reset;
  pixel_t  i_pixel;
  logic    i_pixel_strobe;
  logic    i_read_result;
  logic    o_ready;
  logic    o_frame_end;
  result_t o_result_data;
  logic    o_result_valid;
  logic    o_result_empty;

  pixel_t  frame [FRAME_HEIGHT][FRAME_WIDTH];
  result_t exp_q [$];
  result_t got_q [$];
  int      error_count;
  int      test_start_errors;
  int      tests_run;
  int      tests_failed;
  int      frames_sent;
  int      frame_ends;
  int      cycle_count;
  logic    frame_end_seen;

  face_detection UUT (
    .clk            (clk),
    .reset          (reset),
    .i_pixel        (i_pixel),
    .i_pixel_strobe (i_pixel_strobe),
    .i_read_result  (i_read_result),
    .o_ready        (o_ready),
    .o_frame_end    (o_frame_end),
    .o_result_data  (o_result_data),
    .o_result_valid (o_result_valid),
    .o_result_empty (o_result_empty)
  );

  `include "tb_face_model.svh"

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
  end

  // Count rising edges of the frame-end level
  always @(negedge clk)
  begin
    if (o_frame_end && !frame_end_seen)
    begin
      frame_ends++;
    end
    frame_end_seen = o_frame_end;
  end

  initial
  begin
    wait (cycle_count >= CYCLE_LIMIT);
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TEST FAILED");
    $finish;
  end

  task automatic end_test(input string name);
    tests_run++;
    if (error_count != test_start_errors)
    begin
      tests_failed++;
    end
    $display("%s: %s", name, (error_count == test_start_errors) ? "passed" : "failed");
    test_start_errors = error_count;
  endtask

  task automatic run_frame_test(input bit inject);
    build_expected();
    send_frame(inject);
    drain_results();
    compare_results();
  endtask

  initial
  begin
    reset          = 1'b1;
    i_pixel        = '0;
    i_pixel_strobe = 1'b0;
    i_read_result  = 1'b0;
    error_count    = 0;
    test_start_errors = 0;
    tests_run      = 0;
    tests_failed   = 0;
    frames_sent    = 0;
    frame_ends     = 0;
    frame_end_seen = 1'b0;
    void'($urandom(14));
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;

    assert (o_ready && !o_frame_end && !o_result_valid && o_result_empty)
    else
    begin
      $display("Mismatch at %0t: flags after reset are ready %b end %b valid %b empty %b",
               $time, o_ready, o_frame_end, o_result_valid, o_result_empty);
      error_count++;
    end
    end_test("after reset");

    // Flat grey fails the first stage everywhere
    fill_frame(0);
    run_frame_test(1'b0);
    assert (got_q.size() == 0)
    else
    begin
      $display("Mismatch at %0t: flat frame gave %0d candidates", $time, got_q.size());
      error_count++;
    end
    end_test("flat frame");

    fill_frame(1);
    run_frame_test(1'b0);
    assert (got_q.size() == ALL_TILES)
    else
    begin
      $display("Mismatch at %0t: gradient frame gave %0d of %0d tiles",
               $time, got_q.size(), ALL_TILES);
      error_count++;
    end
    end_test("left bright frame");

    for (int i = 0; i < 3; i++)
    begin
      fill_frame(2);
      run_frame_test(1'b0);
    end
    end_test("random frames");

    fill_frame(2);
    run_frame_test(1'b1);
    end_test("strobes while busy");

    // Read strobe on an empty store must be ignored
    i_read_result = 1'b1;
    @(posedge clk);
    #2;
    i_read_result = 1'b0;
    assert (!o_result_valid && o_result_empty)
    else
    begin
      $display("Mismatch at %0t: read of empty store gave valid data", $time);
      error_count++;
    end
    fill_frame(2);
    run_frame_test(1'b0);
    end_test("read while empty");

    $display("%0d tests run, %0d failed, %0d failed checks",
             tests_run, tests_failed, error_count);
    if (error_count == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+sim
rtl/face_pkg.sv
rtl/tile_accumulator.sv
rtl/cascade_evaluator.sv
rtl/result_fifo.sv
rtl/face_detection.sv
sim/tb_face_detection.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the face detection testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_face_detection -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_face_detection)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
